//--- source/calc_pkg.sv
// Execute cluster definitions
`default_nettype none

package calc_pkg;

  localparam int data_width_lp     = 32;
  localparam int reg_addr_width_lp = 5;
  localparam int comp_depth_lp     = 3;
  localparam int mul_latency_lp    = 2;

  // Next-values of every completion stage, then the registered last stage
  localparam int fwd_els_lp        = comp_depth_lp + 1;

  typedef enum logic
  {
    e_pipe_int = 1'b0
    ,e_pipe_mul = 1'b1
  } pipe_sel_e;

  typedef enum logic [2:0]
  {
    e_alu_add  = 3'd0
    ,e_alu_sub = 3'd1
    ,e_alu_and = 3'd2
    ,e_alu_or  = 3'd3
    ,e_alu_xor = 3'd4
    ,e_alu_sll = 3'd5
    ,e_alu_srl = 3'd6
    ,e_alu_slt = 3'd7
  } alu_op_e;

  typedef struct packed
  {
    logic                         v;
    pipe_sel_e                    pipe_sel;
    alu_op_e                      alu_op;
    logic                         use_imm;
    logic [reg_addr_width_lp-1:0] rs1_addr;
    logic [reg_addr_width_lp-1:0] rs2_addr;
    logic [data_width_lp-1:0]     rs1;
    logic [data_width_lp-1:0]     rs2;
    logic [data_width_lp-1:0]     imm;
    logic [reg_addr_width_lp-1:0] rd_addr;
    logic                         rd_w_v;
  } dispatch_pkt_t;

  typedef struct packed
  {
    logic                         v;
    logic                         rd_w_v;
    logic [reg_addr_width_lp-1:0] rd_addr;
    logic                         mul_v;
  } stage_meta_t;

  // Writeback and forwarding entry
  typedef struct packed
  {
    logic                         v;
    logic [reg_addr_width_lp-1:0] rd_addr;
    logic [data_width_lp-1:0]     data;
  } wb_pkt_t;

endpackage

`default_nettype wire

//--- source/operand_bypass.sv
// Operand bypass and reservation
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
  import calc_pkg::*;
(
  input  logic                     clk_i
  ,input  logic                     rst_n_i
  ,input  logic                     flush_i
  ,input  dispatch_pkt_t            dispatch_pkt_i
  ,input  wb_pkt_t [fwd_els_lp-1:0] fwd_i
  ,output dispatch_pkt_t            rsv_o
);

  dispatch_pkt_t rsv_n;
  dispatch_pkt_t rsv_r;
  logic          rsv_v_r;

  // Entry 0 is the youngest, so it is applied last
  function automatic logic [data_width_lp-1:0] bypass_sel
  (
    input logic [reg_addr_width_lp-1:0] addr
    ,input logic [data_width_lp-1:0]     id_val
    ,input wb_pkt_t [fwd_els_lp-1:0]     fwd
  );
    logic [data_width_lp-1:0] val;
    val = id_val;
    for (int i = fwd_els_lp-1; i >= 0; i--)
    begin
      if (fwd[i].v && (fwd[i].rd_addr == addr))
      begin
        val = fwd[i].data;
      end
    end
    // x0 reads as zero
    if (addr == '0)
    begin
      val = '0;
    end
    return val;
  endfunction

  always_comb
  begin
    rsv_n     = dispatch_pkt_i;
    rsv_n.rs1 = bypass_sel(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1, fwd_i);
    rsv_n.rs2 = bypass_sel(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2, fwd_i);
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rsv_v_r <= 1'b0;
    end
    else
    begin
      rsv_v_r <= dispatch_pkt_i.v & ~flush_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    rsv_r <= rsv_n;
  end

  always_comb
  begin
    rsv_o   = rsv_r;
    rsv_o.v = rsv_v_r;
  end

endmodule

`default_nettype wire

//--- source/pipe_int.sv
// Integer ALU pipe
`timescale 1ns/1ps
`default_nettype none

module pipe_int
  import calc_pkg::*;
(
  input  dispatch_pkt_t            rsv_i
  ,output logic [data_width_lp-1:0] data_o
);

  logic [data_width_lp-1:0]         op_a;
  logic [data_width_lp-1:0]         op_b;
  logic [$clog2(data_width_lp)-1:0] shamt;
  logic                             lt;

  assign op_a  = rsv_i.rs1;
  assign op_b  = rsv_i.use_imm ? rsv_i.imm : rsv_i.rs2;
  assign shamt = op_b[$clog2(data_width_lp)-1:0];
  assign lt    = $signed(op_a) < $signed(op_b);

  always_comb
  begin
    case (rsv_i.alu_op)
      e_alu_add: data_o = op_a + op_b;
      e_alu_sub: data_o = op_a - op_b;
      e_alu_and: data_o = op_a & op_b;
      e_alu_or:  data_o = op_a | op_b;
      e_alu_xor: data_o = op_a ^ op_b;
      e_alu_sll: data_o = op_a << shamt;
      e_alu_srl: data_o = op_a >> shamt;
      e_alu_slt: data_o = {{(data_width_lp-1){1'b0}}, lt};
      default:   data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/pipe_mul.sv
// Pipelined integer multiplier
`timescale 1ns/1ps
`default_nettype none

module pipe_mul
  import calc_pkg::*;
(
  input  logic                     clk_i
  ,input  logic                     rst_n_i
  ,input  dispatch_pkt_t            rsv_i
  ,output logic                     v_o
  ,output logic [data_width_lp-1:0] data_o
);

  logic                                           mul_start;
  logic [mul_latency_lp-1:0]                      v_r;
  logic [data_width_lp-1:0]                       op_a_r;
  logic [data_width_lp-1:0]                       op_b_r;
  logic [mul_latency_lp-2:0][data_width_lp-1:0]   prod_r;

  // Multiplies always take rs1 and rs2
  assign mul_start = rsv_i.v & (rsv_i.pipe_sel == e_pipe_mul);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      v_r <= '0;
    end
    else
    begin
      v_r <= {v_r[mul_latency_lp-2:0], mul_start};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mul_start)
    begin
      op_a_r <= rsv_i.rs1;
      op_b_r <= rsv_i.rs2;
    end
    // Low half only
    prod_r[0] <= op_a_r * op_b_r;
    for (int i = mul_latency_lp-2; i > 0; i--)
    begin
      prod_r[i] <= prod_r[i-1];
    end
  end

  assign v_o    = v_r[mul_latency_lp-1];
  assign data_o = prod_r[mul_latency_lp-2];

endmodule

`default_nettype wire

//--- source/completion_pipe.sv
// Completion pipe and writeback
`timescale 1ns/1ps
`default_nettype none

module completion_pipe
  import calc_pkg::*;
(
  input  logic                     clk_i
  ,input  logic                     rst_n_i
  ,input  logic                     flush_i
  ,input  dispatch_pkt_t            rsv_i
  ,input  logic [data_width_lp-1:0] int_data_i
  ,input  logic                     mul_v_i
  ,input  logic [data_width_lp-1:0] mul_data_i
  ,output wb_pkt_t [fwd_els_lp-1:0] fwd_o
  ,output wb_pkt_t                  wb_pkt_o
);

  localparam int last_lp = comp_depth_lp - 1;

  stage_meta_t [comp_depth_lp-1:0]                meta_n;
  stage_meta_t [comp_depth_lp-1:0]                meta_r;
  logic [comp_depth_lp-1:0][data_width_lp-1:0]    data_n;
  logic [comp_depth_lp-1:0][data_width_lp-1:0]    data_r;
  logic [comp_depth_lp-1:0]                       final_v;

  always_comb
  begin
    meta_n[0].v       = rsv_i.v;
    meta_n[0].rd_w_v  = rsv_i.rd_w_v;
    meta_n[0].rd_addr = rsv_i.rd_addr;
    meta_n[0].mul_v   = (rsv_i.pipe_sel == e_pipe_mul);
    data_n[0]         = int_data_i;
    for (int i = 1; i < comp_depth_lp; i++)
    begin
      meta_n[i] = meta_r[i-1];
      data_n[i] = data_r[i-1];
    end
    // Multiply result lands as its instruction enters the last stage
    if (mul_v_i)
    begin
      data_n[last_lp] = mul_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      meta_r <= '0;
    end
    else
    begin
      meta_r <= meta_n;
      if (flush_i)
      begin
        for (int i = 0; i < comp_depth_lp; i++)
        begin
          meta_r[i].v <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    data_r <= data_n;
  end

  always_comb
  begin
    wb_pkt_o.v       = meta_r[last_lp].v & meta_r[last_lp].rd_w_v;
    wb_pkt_o.rd_addr = meta_r[last_lp].rd_addr;
    wb_pkt_o.data    = data_r[last_lp];
  end

  // Multiply data is final only from the last stage onwards
  always_comb
  begin
    for (int i = 0; i < comp_depth_lp; i++)
    begin
      final_v[i]        = ~meta_n[i].mul_v | (i == last_lp);
      fwd_o[i].v        = meta_n[i].v & meta_n[i].rd_w_v & final_v[i];
      fwd_o[i].rd_addr  = meta_n[i].rd_addr;
      fwd_o[i].data     = data_n[i];
    end
    fwd_o[fwd_els_lp-1] = wb_pkt_o;
  end

endmodule

`default_nettype wire

//--- source/calc_top.sv
// Execute cluster top
`timescale 1ns/1ps
`default_nettype none

module calc_top
  import calc_pkg::*;
(
  input  logic          clk_i
  ,input  logic          rst_n_i
  ,input  logic          flush_i
  ,input  dispatch_pkt_t dispatch_pkt_i
  ,output wb_pkt_t       wb_pkt_o
);

  dispatch_pkt_t                  rsv;
  wb_pkt_t [fwd_els_lp-1:0]       fwd;
  logic [data_width_lp-1:0]       int_data;
  logic                           mul_v;
  logic [data_width_lp-1:0]       mul_data;

  operand_bypass bypass
  (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.flush_i(flush_i)
    ,.dispatch_pkt_i(dispatch_pkt_i)
    ,.fwd_i(fwd)
    ,.rsv_o(rsv)
  );

  pipe_int int_pipe
  (
    .rsv_i(rsv)
    ,.data_o(int_data)
  );

  pipe_mul mul_pipe
  (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.rsv_i(rsv)
    ,.v_o(mul_v)
    ,.data_o(mul_data)
  );

  completion_pipe comp_pipe
  (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.flush_i(flush_i)
    ,.rsv_i(rsv)
    ,.int_data_i(int_data)
    ,.mul_v_i(mul_v)
    ,.mul_data_i(mul_data)
    ,.fwd_o(fwd)
    ,.wb_pkt_o(wb_pkt_o)
  );

endmodule

`default_nettype wire

//--- bench/calc_ref.svh
// Execute cluster reference model
`ifndef CALC_REF_SVH
`define CALC_REF_SVH

// Result of one instruction from its architecturally correct operands
function automatic logic [31:0] calc_ref
(
  input pipe_sel_e   sel
  ,input alu_op_e     op
  ,input logic        use_imm
  ,input logic [31:0] a
  ,input logic [31:0] b
  ,input logic [31:0] imm
);
  logic [63:0] prod;
  logic [31:0] opnd;
  logic [4:0]  sh;
  prod = {32'b0, a} * {32'b0, b};
  opnd = use_imm ? imm : b;
  sh   = opnd[4:0];
  if (sel == e_pipe_mul)
  begin
    return prod[31:0];
  end
  case (op)
    e_alu_add: return a + opnd;
    e_alu_sub: return a - opnd;
    e_alu_and: return a & opnd;
    e_alu_or:  return a | opnd;
    e_alu_xor: return a ^ opnd;
    e_alu_sll: return a << sh;
    e_alu_srl: return a >> sh;
    default:   return ($signed(a) < $signed(opnd)) ? 32'd1 : 32'd0;
  endcase
endfunction

`endif

//--- bench/calc_tb.sv
// Execute cluster testbench
`timescale 1ns/1ps
`default_nettype none

module calc_tb
  import calc_pkg::*;
();

  `include "calc_ref.svh"

  localparam int cycle_limit_lp = 2000;

  typedef struct packed
  {
    logic [4:0]  rd;
    logic [31:0] data;
    int unsigned cyc;
  } exp_t;

  logic          clk_i;
  logic          rst_n_i;
  logic          flush_i;
  dispatch_pkt_t dispatch_pkt_i;
  wb_pkt_t       wb_pkt_o;

  logic [31:0]   stale_regs [32];
  logic [31:0]   arch_regs [32];
  int            mul_slot [32];
  exp_t          expect_q [$];
  int            slot;
  int unsigned   cycle_cnt;
  int            pass_cnt;
  int            fail_cnt;
  int            test_base;

  calc_top dut0
  (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.flush_i(flush_i)
    ,.dispatch_pkt_i(dispatch_pkt_i)
    ,.wb_pkt_o(wb_pkt_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #10 clk_i = ~clk_i;
    end
  end

  function automatic logic mul_conflict(input logic [4:0] rs, input logic used);
    return used && (rs != 5'd0) && (slot - mul_slot[rs] < 3);
  endfunction

  task automatic idle();
    @(posedge clk_i);
    dispatch_pkt_i <= '0;
    flush_i        <= 1'b0;
    slot++;
  endtask

  // One dispatch slot; killed instructions are expected to vanish in a flush
  task automatic send
  (
    input pipe_sel_e   sel
    ,input alu_op_e     op
    ,input logic        use_imm
    ,input logic [4:0]  rs1_a
    ,input logic [4:0]  rs2_a
    ,input logic [31:0] imm
    ,input logic [4:0]  rd
    ,input logic        rd_w_v
    ,input logic        kill
    ,input logic        do_flush
  );
    dispatch_pkt_t pkt;
    exp_t          e;
    logic          rs2_used;
    rs2_used = (sel == e_pipe_mul) || !use_imm;
    while (mul_conflict(rs1_a, 1'b1) || mul_conflict(rs2_a, rs2_used))
    begin
      idle();
    end
    @(posedge clk_i);
    pkt          = '0;
    pkt.v        = 1'b1;
    pkt.pipe_sel = sel;
    pkt.alu_op   = op;
    pkt.use_imm  = use_imm;
    pkt.rs1_addr = rs1_a;
    pkt.rs2_addr = rs2_a;
    // Junk for x0 so the DUT must force zero
    pkt.rs1      = (rs1_a == 5'd0) ? $urandom : stale_regs[rs1_a];
    pkt.rs2      = (rs2_a == 5'd0) ? $urandom : stale_regs[rs2_a];
    pkt.imm      = imm;
    pkt.rd_addr  = rd;
    pkt.rd_w_v   = rd_w_v;
    dispatch_pkt_i <= pkt;
    flush_i        <= do_flush;
    if (!kill && rd_w_v)
    begin
      e.rd   = rd;
      e.data = calc_ref(sel, op, use_imm, arch_regs[rs1_a], arch_regs[rs2_a], imm);
      e.cyc  = cycle_cnt + 5;
      expect_q.push_back(e);
      if (rd != 5'd0)
      begin
        arch_regs[rd] = e.data;
      end
      mul_slot[rd] = (sel == e_pipe_mul) ? slot : -1000;
    end
    slot++;
  endtask

  task automatic drain();
    while (expect_q.size() != 0)
    begin
      idle();
    end
    repeat (4) idle();
  endtask

  task automatic report(input string name);
    $display("test %s: %0d errors", name, fail_cnt - test_base);
    test_base = fail_cnt;
  endtask

  // Checker and cycle counter
  always @(negedge clk_i)
  begin
    exp_t e;
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit_lp)
    begin
      $display("timeout after %0d cycles with %0d writebacks pending",
               cycle_cnt, expect_q.size());
      $display("Simulation failed");
      $finish;
    end
    else if (rst_n_i !== 1'b0 && wb_pkt_o.v !== 1'b0)
    begin
      assert (expect_q.size() != 0)
      else
      begin
        fail_cnt++;
        $display("unexpected writeback to register %0d when none was due",
                 wb_pkt_o.rd_addr);
      end
      if (expect_q.size() != 0)
      begin
        e = expect_q.pop_front();
        assert (wb_pkt_o.rd_addr == e.rd) pass_cnt++;
        else
        begin
          fail_cnt++;
          $display("mismatch wb_pkt_o.rd_addr: got %h expected %h", wb_pkt_o.rd_addr, e.rd);
        end
        assert (wb_pkt_o.data == e.data) pass_cnt++;
        else
        begin
          fail_cnt++;
          $display("mismatch wb_pkt_o.data: got %h expected %h", wb_pkt_o.data, e.data);
        end
        assert (cycle_cnt == e.cyc) pass_cnt++;
        else
        begin
          fail_cnt++;
          $display("writeback came in cycle %0d but was due in cycle %0d", cycle_cnt, e.cyc);
        end
        if (e.rd != 5'd0)
        begin
          stale_regs[e.rd] = e.data;
        end
      end
    end
  end

  initial
  begin
    logic [2:0]  op_r;
    logic [4:0]  rd_r;
    logic [4:0]  rs1_r;
    logic [4:0]  rs2_r;
    logic        imm_r;
    pipe_sel_e   sel_r;
    void'($urandom(32'hc156_43ec));
    rst_n_i        = 1'b0;
    flush_i        = 1'b0;
    dispatch_pkt_i = '0;
    slot           = 0;
    cycle_cnt      = 0;
    pass_cnt       = 0;
    fail_cnt       = 0;
    test_base      = 0;
    for (int i = 0; i < 32; i++)
    begin
      stale_regs[i] = '0;
      arch_regs[i]  = '0;
      mul_slot[i]   = -1000;
    end
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (6) idle();

    // Load constants, then every ALU op on settled registers
    send(e_pipe_int, e_alu_add, 1'b1, 5'd0, 5'd0, 32'h1234_5678, 5'd1, 1'b1, 1'b0, 1'b0);
    send(e_pipe_int, e_alu_add, 1'b1, 5'd0, 5'd0, 32'hf0f0_0013, 5'd2, 1'b1, 1'b0, 1'b0);
    send(e_pipe_int, e_alu_add, 1'b1, 5'd0, 5'd0, 32'h8000_0001, 5'd3, 1'b1, 1'b0, 1'b0);
    send(e_pipe_int, e_alu_add, 1'b1, 5'd0, 5'd0, 32'h0000_0007, 5'd4, 1'b1, 1'b0, 1'b0);
    drain();
    for (int op = 0; op < 8; op++)
    begin
      for (int im = 0; im < 2; im++)
      begin
        send(e_pipe_int, alu_op_e'(op[2:0]), im[0], 5'(1 + op % 4), 5'(1 + (op + 1) % 4),
             32'hffff_ff09, 5'(10 + op * 2 + im), 1'b1, 1'b0, 1'b0);
      end
    end
    drain();
    report("alu_ops");

    // Dependent chains through the bypass
    for (int d = 1; d <= 3; d++)
    begin
      send(e_pipe_int, e_alu_add, 1'b1, 5'd1, 5'd0, 32'(d), 5'd20, 1'b1, 1'b0, 1'b0);
      for (int k = 0; k < 6; k++)
      begin
        repeat (d - 1) idle();
        send(e_pipe_int, alu_op_e'(3'(k % 3 == 2 ? 5 : k % 3 * 4)), k[0] | (k % 3 == 1),
             5'd20, 5'd20, 32'h0000_0103 + 32'(k), 5'd20, 1'b1, 1'b0, 1'b0);
      end
      drain();
    end
    report("bypass_chains");

    // Multiplies, two in flight, then dependents
    send(e_pipe_mul, e_alu_add, 1'b0, 5'd1, 5'd2, 32'h0, 5'd5, 1'b1, 1'b0, 1'b0);
    send(e_pipe_mul, e_alu_add, 1'b0, 5'd3, 5'd4, 32'h0, 5'd6, 1'b1, 1'b0, 1'b0);
    send(e_pipe_mul, e_alu_add, 1'b0, 5'd5, 5'd6, 32'h0, 5'd7, 1'b1, 1'b0, 1'b0);
    send(e_pipe_int, e_alu_add, 1'b0, 5'd7, 5'd5, 32'h0, 5'd8, 1'b1, 1'b0, 1'b0);
    drain();
    report("multiply");

    // x0 as a target in flight and as a source
    send(e_pipe_int, e_alu_add, 1'b1, 5'd1, 5'd0, 32'h0000_0055, 5'd0, 1'b1, 1'b0, 1'b0);
    send(e_pipe_int, e_alu_add, 1'b1, 5'd0, 5'd0, 32'h0000_0011, 5'd12, 1'b1, 1'b0, 1'b0);
    send(e_pipe_int, e_alu_or, 1'b0, 5'd0, 5'd1, 32'h0, 5'd13, 1'b1, 1'b0, 1'b0);
    drain();
    report("x0_reads");

    // One survivor, four killed by the flush, then normal work
    send(e_pipe_int, e_alu_add, 1'b1, 5'd1, 5'd0, 32'h1, 5'd14, 1'b1, 1'b0, 1'b0);
    send(e_pipe_int, e_alu_add, 1'b1, 5'd2, 5'd0, 32'h9, 5'd15, 1'b1, 1'b1, 1'b0);
    send(e_pipe_mul, e_alu_add, 1'b0, 5'd1, 5'd2, 32'h0, 5'd16, 1'b1, 1'b1, 1'b0);
    send(e_pipe_int, e_alu_add, 1'b1, 5'd14, 5'd0, 32'h64, 5'd14, 1'b1, 1'b1, 1'b0);
    send(e_pipe_int, e_alu_xor, 1'b0, 5'd1, 5'd2, 32'h0, 5'd17, 1'b1, 1'b1, 1'b1);
    send(e_pipe_int, e_alu_add, 1'b1, 5'd14, 5'd0, 32'h0, 5'd18, 1'b1, 1'b0, 1'b0);
    send(e_pipe_int, e_alu_or, 1'b0, 5'd15, 5'd16, 32'h0, 5'd19, 1'b1, 1'b0, 1'b0);
    drain();
    report("flush");

    // Random mix under the multiply spacing rule
    for (int n = 0; n < 440; n++)
    begin
      op_r  = 3'($urandom_range(7));
      rs1_r = 5'($urandom_range(31));
      rs2_r = 5'($urandom_range(31));
      rd_r  = ($urandom_range(9) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
      imm_r = 1'($urandom_range(1));
      sel_r = ($urandom_range(3) == 0) ? e_pipe_mul : e_pipe_int;
      send(sel_r, alu_op_e'(op_r), imm_r, rs1_r, rs2_r, $urandom, rd_r,
           $urandom_range(9) != 0, 1'b0, 1'b0);
    end
    drain();
    report("random_mix");

    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+bench
source/calc_pkg.sv
source/operand_bypass.sv
source/pipe_int.sv
source/pipe_mul.sv
source/completion_pipe.sv
source/calc_top.sv
bench/calc_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module calc_tb -o calc_sim --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "compile step returned status $status"
  exit 1
fi

./obj_dir/calc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi

exit 0
